/* verilog/tpu_pkg.sv */
package tpu_pkg;

    //##########################################################
    // array geometry
    //##########################################################

    // edge of the grid, also the number of lanes per bank side
    localparam int ARRAY_DIM = 4;
    // deepest inner dimension and bank depth
    localparam int K_MAX     = 16;
    localparam int IDX_W     = 4;
    localparam int OPND_W    = 16;
    localparam int ACC_W     = 32;

    // cycles from the last operand read until cell (3,3) has its product
    localparam int FLUSH_CYCLES = 8;

    //##########################################################
    // bus and address map
    //##########################################################

    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // region code sits in adr[7:6]
    localparam logic [1:0] REG_ROW_BANK = 2'd0;
    localparam logic [1:0] REG_COL_BANK = 2'd1;
    localparam logic [1:0] REG_CTRL     = 2'd2;
    localparam logic [1:0] REG_RESULT   = 2'd3;

    //##########################################################
    // types
    //##########################################################

    typedef logic signed [OPND_W-1:0] operand_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // one software store into a row or column bank
    typedef struct packed {
        logic             en;
        logic             col_sel;
        logic [1:0]       lane;
        logic [IDX_W-1:0] index;
        operand_t         value;
    } bank_wr_t;

    // one k step for all lanes, plus accumulator clear
    typedef struct packed {
        logic                       valid;
        logic                       clear;
        operand_t [ARRAY_DIM-1:0]   row;
        operand_t [ARRAY_DIM-1:0]   col;
    } feed_t;

    // entry i*4+j holds C[i][j]
    typedef acc_t [ARRAY_DIM*ARRAY_DIM-1:0] acc_grid_t;

endpackage

/* verilog/wb_cmd_port.sv */
module wb_cmd_port (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  tpu_pkg::wb_req_t        wb_i,
    output tpu_pkg::wb_rsp_t        wb_o,
    input  logic                    busy_i,
    input  tpu_pkg::acc_grid_t      acc_i,
    output tpu_pkg::bank_wr_t       bank_wr_o,
    output logic                    start_o,
    output logic [tpu_pkg::IDX_W:0] k_len_o
);
    import tpu_pkg::*;

    logic                ack_q;
    logic [WB_DAT_W-1:0] rd_q;
    logic [WB_DAT_W-1:0] rd_word;
    logic                req;
    logic [1:0]          region;
    logic                ctrl_ofs0;
    logic                bank_hit;
    logic                k_ok;

    //##########################################################
    // decode
    //##########################################################

    // new access only while ack is low, so every access gets one wait state
    assign req       = wb_i.cyc && wb_i.stb && !ack_q;
    assign region    = wb_i.adr[7:6];
    assign ctrl_ofs0 = (region == REG_CTRL) && (wb_i.adr[5:0] == 6'd0);

    assign k_len_o = wb_i.dat[IDX_W:0];
    assign k_ok    = (k_len_o != '0) && (k_len_o <= K_MAX);

    // banks are frozen while a run reads them
    assign bank_hit = req && wb_i.we && !busy_i
                      && ((region == REG_ROW_BANK) || (region == REG_COL_BANK));

    // start is a single pulse on the acking edge
    assign start_o = req && wb_i.we && ctrl_ofs0 && !busy_i && k_ok;

    //##########################################################
    // readback
    //##########################################################

    always_comb begin
        rd_word = '0;
        case (region)
            REG_CTRL: begin
                if (wb_i.adr[5:0] == 6'd0) begin
                    rd_word[0] = busy_i;
                end
            end
            REG_RESULT: begin
                rd_word = acc_i[wb_i.adr[3:0]];
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // write cycles return zero on the data lines
    always_ff @(posedge clk_i) begin
        if (req) begin
            rd_q <= wb_i.we ? '0 : rd_word;
        end
    end

    always_comb begin
        wb_o.ack = ack_q;
        wb_o.dat = ack_q ? rd_q : '0;
    end

    //##########################################################
    // bank write
    //##########################################################

    always_ff @(posedge clk_i) begin
        bank_wr_o.col_sel <= (region == REG_COL_BANK);
        bank_wr_o.lane    <= wb_i.adr[5:4];
        bank_wr_o.index   <= wb_i.adr[IDX_W-1:0];
        bank_wr_o.value   <= wb_i.dat[OPND_W-1:0];
        if (rst_i) begin
            bank_wr_o.en <= 1'b0;
        end else begin
            bank_wr_o.en <= bank_hit;
        end
    end

endmodule

/* verilog/tile_sequencer.sv */
module tile_sequencer (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      start_i,
    input  logic [tpu_pkg::IDX_W:0]   k_len_i,
    output logic                      busy_o,
    output logic                      rd_en_o,
    output logic [tpu_pkg::IDX_W-1:0] rd_index_o,
    output logic                      clear_o
);
    import tpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE_S,
        FEED_S,
        FLUSH_S
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic [IDX_W-1:0] cnt_q;
    logic [IDX_W-1:0] k_last_q;
    logic             cnt_done;

    // counter end depends on the phase
    always_comb begin
        if (state_q == FEED_S) begin
            cnt_done = (cnt_q == k_last_q);
        end else begin
            cnt_done = (cnt_q == IDX_W'(FLUSH_CYCLES - 1));
        end
    end

    //##########################################################
    // state
    //##########################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE_S: begin
                if (start_i) begin
                    state_d = FEED_S;
                end
            end
            FEED_S: begin
                if (cnt_done) begin
                    state_d = FLUSH_S;
                end
            end
            FLUSH_S: begin
                if (cnt_done) begin
                    state_d = IDLE_S;
                end
            end
            default: begin
                state_d = IDLE_S;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE_S;
        end else begin
            state_q <= state_d;
        end
    end

    // one counter, restarted on every phase change
    always_ff @(posedge clk_i) begin
        if (rst_i || (state_q == IDLE_S) || (state_d != state_q)) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // K of 16 wraps to 15 here
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            k_last_q <= k_len_i[IDX_W-1:0] - 1'b1;
        end
    end

    assign busy_o     = (state_q != IDLE_S);
    assign rd_en_o    = (state_q == FEED_S);
    assign rd_index_o = cnt_q;
    // wipe the grid before the first operands arrive
    assign clear_o    = start_i;

endmodule

/* verilog/operand_banks.sv */
module operand_banks (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  tpu_pkg::bank_wr_t         bank_wr_i,
    input  logic                      rd_en_i,
    input  logic [tpu_pkg::IDX_W-1:0] rd_index_i,
    input  logic                      clear_i,
    output tpu_pkg::feed_t            feed_o
);
    import tpu_pkg::*;

    // side 0 holds the A rows, side 1 the B columns
    operand_t         mem [2][ARRAY_DIM][K_MAX];
    logic [IDX_W-1:0] bank_addr;

    //##########################################################
    // shared address port
    //##########################################################

    // software owns the port while idle, the sequencer while busy
    assign bank_addr = bank_wr_i.en ? bank_wr_i.index : rd_index_i;

    always_ff @(posedge clk_i) begin
        if (bank_wr_i.en) begin
            mem[bank_wr_i.col_sel][bank_wr_i.lane][bank_addr] <= bank_wr_i.value;
        end
    end

    //##########################################################
    // registered read of all eight lanes
    //##########################################################

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int l = 0; l < ARRAY_DIM; l++) begin
                feed_o.row[l] <= mem[0][l][bank_addr];
                feed_o.col[l] <= mem[1][l][bank_addr];
            end
        end
        // flags follow the data with the same latency
        if (rst_i) begin
            feed_o.valid <= 1'b0;
            feed_o.clear <= 1'b0;
        end else begin
            feed_o.valid <= rd_en_i;
            feed_o.clear <= clear_i;
        end
    end

endmodule

/* verilog/systolic_array.sv */
module systolic_array (
    input  logic               clk_i,
    input  logic               rst_i,
    input  tpu_pkg::feed_t     feed_i,
    output tpu_pkg::acc_grid_t acc_o
);
    import tpu_pkg::*;

    // side 0 enters from the west (A rows), side 1 from the north (B columns)
    operand_t lane_d [2][ARRAY_DIM];
    operand_t edge_d [2][ARRAY_DIM];
    logic     edge_v [2][ARRAY_DIM];

    // east and south pass-through registers of every cell
    operand_t a_q   [ARRAY_DIM][ARRAY_DIM];
    logic     av_q  [ARRAY_DIM][ARRAY_DIM];
    operand_t b_q   [ARRAY_DIM][ARRAY_DIM];
    logic     bv_q  [ARRAY_DIM][ARRAY_DIM];
    acc_t     acc_q [ARRAY_DIM][ARRAY_DIM];

    always_comb begin
        for (int l = 0; l < ARRAY_DIM; l++) begin
            lane_d[0][l] = feed_i.row[l];
            lane_d[1][l] = feed_i.col[l];
        end
    end

    //##########################################################
    // input skew, lane l delayed by l cycles
    //##########################################################

    for (genvar s = 0; s < 2; s++) begin : g_side
        for (genvar l = 0; l < ARRAY_DIM; l++) begin : g_lane
            if (l == 0) begin : g_direct
                assign edge_d[s][l] = lane_d[s][l];
                assign edge_v[s][l] = feed_i.valid;
            end else begin : g_delay
                operand_t sr_d [l];
                logic     sr_v [l];

                always_ff @(posedge clk_i) begin
                    sr_d[0] <= lane_d[s][l];
                    for (int t = 1; t < l; t++) begin
                        sr_d[t] <= sr_d[t-1];
                    end
                    if (rst_i) begin
                        for (int t = 0; t < l; t++) begin
                            sr_v[t] <= 1'b0;
                        end
                    end else begin
                        sr_v[0] <= feed_i.valid;
                        for (int t = 1; t < l; t++) begin
                            sr_v[t] <= sr_v[t-1];
                        end
                    end
                end

                assign edge_d[s][l] = sr_d[l-1];
                assign edge_v[s][l] = sr_v[l-1];
            end
        end
    end

    //##########################################################
    // multiply-accumulate grid
    //##########################################################

    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_row
        for (genvar j = 0; j < ARRAY_DIM; j++) begin : g_col
            operand_t a_in;
            operand_t b_in;
            logic     av_in;
            logic     bv_in;
            acc_t     prod;

            if (j == 0) begin : g_west
                assign a_in  = edge_d[0][i];
                assign av_in = edge_v[0][i];
            end else begin : g_from_left
                assign a_in  = a_q[i][j-1];
                assign av_in = av_q[i][j-1];
            end

            if (i == 0) begin : g_north
                assign b_in  = edge_d[1][j];
                assign bv_in = edge_v[1][j];
            end else begin : g_from_above
                assign b_in  = b_q[i-1][j];
                assign bv_in = bv_q[i-1][j];
            end

            // signed operands widen to 32 bits before the multiply
            assign prod = a_in * b_in;

            always_ff @(posedge clk_i) begin
                a_q[i][j] <= a_in;
                b_q[i][j] <= b_in;
                if (rst_i) begin
                    av_q[i][j]  <= 1'b0;
                    bv_q[i][j]  <= 1'b0;
                    acc_q[i][j] <= '0;
                end else begin
                    av_q[i][j] <= av_in;
                    bv_q[i][j] <= bv_in;
                    if (feed_i.clear) begin
                        acc_q[i][j] <= '0;
                    end else if (av_in && bv_in) begin
                        acc_q[i][j] <= acc_q[i][j] + prod;
                    end
                end
            end
        end
    end

    // row-major result word
    always_comb begin
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                acc_o[i*ARRAY_DIM + j] = acc_q[i][j];
            end
        end
    end

endmodule

/* verilog/tpu_top.sv */
module tpu_top (
    input  logic             clk_i,
    input  logic             rst_i,
    input  tpu_pkg::wb_req_t wb_i,
    output tpu_pkg::wb_rsp_t wb_o
);
    import tpu_pkg::*;

    bank_wr_t         bank_wr;
    logic             start;
    logic [IDX_W:0]   k_len;
    logic             busy;
    logic             rd_en;
    logic [IDX_W-1:0] rd_index;
    logic             clear;
    feed_t            feed;
    acc_grid_t        acc;

    wb_cmd_port wb_cmd_port_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_i      (wb_i),
        .wb_o      (wb_o),
        .busy_i    (busy),
        .acc_i     (acc),
        .bank_wr_o (bank_wr),
        .start_o   (start),
        .k_len_o   (k_len)
    );

    // producer
    tile_sequencer tile_sequencer_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (start),
        .k_len_i    (k_len),
        .busy_o     (busy),
        .rd_en_o    (rd_en),
        .rd_index_o (rd_index),
        .clear_o    (clear)
    );

    operand_banks operand_banks_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .bank_wr_i  (bank_wr),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .clear_i    (clear),
        .feed_o     (feed)
    );

    // consumer
    systolic_array systolic_array_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .feed_i (feed),
        .acc_o  (acc)
    );

endmodule

/* tests/tpu_assertions.sv */
module tpu_assertions (
    input logic             clk_i,
    input logic             rst_i,
    input tpu_pkg::wb_req_t wb_i,
    input tpu_pkg::wb_rsp_t wb_o,
    input logic             busy_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import tpu_pkg::*;

    logic bus_open;
    logic ctrl_write;

    assign bus_open   = wb_i.cyc && wb_i.stb;
    assign ctrl_write = bus_open && wb_i.we && (wb_i.adr[7:6] == REG_CTRL);

    //##########################################################
    // sampled on the falling edge, where ack and the request overlap
    //##########################################################

    ack_in_cycle: assert property (@(negedge clk_i) disable iff (rst_i)
        wb_o.ack |-> bus_open)
        else $error("ack seen without an open bus cycle");

    ack_one_clock: assert property (@(negedge clk_i) disable iff (rst_i)
        wb_o.ack |=> !wb_o.ack)
        else $error("ack high on two consecutive cycles");

    // busy may only come from an acknowledged start
    busy_from_start: assert property (@(negedge clk_i) disable iff (rst_i)
        $rose(busy_i) |-> (wb_o.ack && ctrl_write))
        else $error("busy rose without an acknowledged control write");

endmodule

bind tpu_top tpu_assertions tpu_assertions_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .wb_i   (wb_i),
    .wb_o   (wb_o),
    .busy_i (busy)
);

/* tests/tb_tpu.sv */
module tb_tpu;
    timeunit 1ns;
    timeprecision 100ps;

    import tpu_pkg::*;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_TIMEOUT  = 20;
    localparam int IDLE_POLLS   = 50;
    localparam int LOOP_CASES   = 3;
    localparam int VEC_DEPTH    = 512;
    localparam logic [WB_ADR_W-1:0] CTRL_ADR = {REG_CTRL, 6'd0};

    logic    clk_i = 1'b0;
    logic    rst_i;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    logic [WB_DAT_W-1:0] vec_mem [VEC_DEPTH];
    int                  vec_ptr;
    acc_t                exp_c [ARRAY_DIM*ARRAY_DIM];
    int                  mismatch_count  = 0;
    int                  timeout_count   = 0;
    int                  bus_error_count = 0;

    tpu_top tpu_top_inst (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .wb_i  (wb_req),
        .wb_o  (wb_rsp)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    //##########################################################
    // bus access
    //##########################################################

    // one classic cycle, then one idle cycle in which ack must be gone
    task automatic run_transfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                                input logic [WB_DAT_W-1:0] wdat,
                                output logic [WB_DAT_W-1:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk_i);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk_i);
        while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
            waited++;
            @(negedge clk_i);
        end
        rdat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            $display("ERROR: no ack for access to 0x%02h within %0d cycles", adr, ACK_TIMEOUT);
            timeout_count++;
        end
        wb_req = '0;
        @(negedge clk_i);
        if (wb_rsp.ack) begin
            $display("ERROR: ack for access to 0x%02h stayed high a second cycle", adr);
            bus_error_count++;
        end
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused_rd;
        run_transfer(1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] dat);
        run_transfer(1'b0, adr, '0, dat);
    endtask

    // poll busy until the run has drained
    task automatic wait_idle();
        logic [WB_DAT_W-1:0] status;
        int                  polls;
        polls = 0;
        wb_read(CTRL_ADR, status);
        while (status[0] && polls < IDLE_POLLS) begin
            polls++;
            wb_read(CTRL_ADR, status);
        end
        if (status[0]) begin
            $display("ERROR: DUT still busy after %0d status polls", IDLE_POLLS);
            timeout_count++;
        end
    endtask

    //##########################################################
    // compare tasks
    //##########################################################

    task automatic check_acc(input acc_t expected, input acc_t actual,
                             input int row, input int col);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: C[%0d][%0d] reads %0d, expected %0d",
                     $time, row, col, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_status(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: busy %s reads %b, expected %b",
                     $time, what, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_word(input logic [WB_DAT_W-1:0] expected,
                              input logic [WB_DAT_W-1:0] actual,
                              input logic [WB_ADR_W-1:0] adr);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: word at 0x%02h reads 0x%08h, expected 0x%08h",
                     $time, adr, actual, expected);
            mismatch_count++;
        end
    endtask

    //##########################################################
    // case handling
    //##########################################################

    // A row by row, then B row by row, then the expected grid
    task automatic load_case(output int k_len);
        k_len = int'(vec_mem[vec_ptr]);
        vec_ptr++;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int k = 0; k < k_len; k++) begin
                wb_write({REG_ROW_BANK, 2'(i), 4'(k)}, vec_mem[vec_ptr]);
                vec_ptr++;
            end
        end
        for (int k = 0; k < k_len; k++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                wb_write({REG_COL_BANK, 2'(j), 4'(k)}, vec_mem[vec_ptr]);
                vec_ptr++;
            end
        end
        for (int n = 0; n < ARRAY_DIM*ARRAY_DIM; n++) begin
            exp_c[n] = acc_t'(vec_mem[vec_ptr]);
            vec_ptr++;
        end
    endtask

    task automatic check_results();
        logic [WB_DAT_W-1:0] word;
        for (int n = 0; n < ARRAY_DIM*ARRAY_DIM; n++) begin
            wb_read({REG_RESULT, 2'b00, 4'(n)}, word);
            check_acc(exp_c[n], acc_t'(word), n / ARRAY_DIM, n % ARRAY_DIM);
        end
    endtask

    initial begin
        int                  k_len;
        logic [WB_DAT_W-1:0] word;

        rst_i   = 1'b1;
        wb_req  = '0;
        vec_ptr = 0;
        $readmemh("tests/tpu_tests.mem", vec_mem);
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // K of 1, K of 16, then K of 3 right after without a reset
        for (int c = 0; c < LOOP_CASES; c++) begin
            load_case(k_len);
            wb_write(CTRL_ADR, WB_DAT_W'(k_len));
            wait_idle();
            wb_read(CTRL_ADR, word);
            check_status(1'b0, word[0], "after run");
            check_results();
        end

        // start rules
        load_case(k_len);
        wb_write(CTRL_ADR, WB_DAT_W'(k_len));
        wb_read(CTRL_ADR, word);
        check_status(1'b1, word[0], "right after start");
        // would restart with K of 1 if taken
        wb_write(CTRL_ADR, 32'd1);
        wait_idle();
        wb_read(CTRL_ADR, word);
        check_status(1'b0, word[0], "after run");
        check_results();
        wb_write(CTRL_ADR, 32'd0);
        wb_read(CTRL_ADR, word);
        check_status(1'b0, word[0], "after start with K of 0");
        wb_write(CTRL_ADR, 32'd17);
        wb_read(CTRL_ADR, word);
        check_status(1'b0, word[0], "after start with K of 17");
        check_results();

        // address map
        load_case(k_len);
        wb_write(CTRL_ADR, WB_DAT_W'(k_len));
        // other control offsets read while busy is still high
        wb_read({REG_CTRL, 6'h01}, word);
        check_word('0, word, {REG_CTRL, 6'h01});
        wb_read({REG_CTRL, 6'h2a}, word);
        check_word('0, word, {REG_CTRL, 6'h2a});
        wb_read({REG_CTRL, 6'h3f}, word);
        check_word('0, word, {REG_CTRL, 6'h3f});
        wait_idle();
        check_results();
        wb_write({REG_RESULT, 6'h05}, 32'hdead_beef);
        wb_write({REG_CTRL, 6'h09}, 32'd4);
        wb_read(CTRL_ADR, word);
        check_status(1'b0, word[0], "after write to unused control offset");
        check_results();

        $display("tb_tpu summary: %0d mismatches, %0d timeouts, %0d bus errors",
                 mismatch_count, timeout_count, bus_error_count);
        if (mismatch_count == 0 && timeout_count == 0 && bus_error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tests/tpu_tests.mem */
// per case: K, then A row by row (K words per row), then B row by row (4 words per k),
// then the expected C grid row-major as 32-bit two's complement words
// case 1, K = 1
01
0002 FFFD 0007 0100
0005 FFFF 0064 FFF9
0000000A FFFFFFFE 000000C8 FFFFFFF2 FFFFFFF1 00000003 FFFFFED4 00000015
00000023 FFFFFFF9 000002BC FFFFFFCF 00000500 FFFFFF00 00006400 FFFFF900
// case 2, K = 16, full scale operands
10
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
8000 7FFF FED4 0005 8000 7FFF FED4 0005
00000000 00080000 09600000 FFD80000 00080000 FFF00010 F6A012C0 0027FFB0
00080000 FFF80010 000012C0 FFFFFFB0 E0C00000 1F3FC180 FFB6C200 00013880
// case 3, K = 3
03
0001 0002 0003
FFFF 0000 0004
000A FFF6 0005
0000 0001 FFFE
0001 FFFE 0003 0000
0004 0005 FFFA 0007
FFFF 0002 0000 0003
00000006 0000000E FFFFFFF7 00000017 FFFFFFFB 0000000A FFFFFFFD 0000000C
FFFFFFDD FFFFFFC4 0000005A FFFFFFC9 00000006 00000001 FFFFFFFA 00000001
// case 4, K = 2
02
0003 FFFC
0001 0001
FFFE 0005
0064 00C8
0001 0000 FFFF 0002
0000 0001 0003 FFFE
00000003 FFFFFFFC FFFFFFF1 0000000E 00000001 00000001 00000002 00000000
FFFFFFFE 00000005 00000011 FFFFFFF2 00000064 000000C8 000001F4 FFFFFF38
// case 5, K = 4, B is the negated identity
04
0001 0002 0003 0004
FFFB 0006 7FFF 8000
0000 0000 0000 0009
0100 FFFF 0002 FFFD
FFFF 0000 0000 0000
0000 FFFF 0000 0000
0000 0000 FFFF 0000
0000 0000 0000 FFFF
FFFFFFFF FFFFFFFE FFFFFFFD FFFFFFFC 00000005 FFFFFFFA FFFF8001 00008000
00000000 00000000 00000000 FFFFFFF7 FFFFFF00 00000001 FFFFFFFE 00000003

/* tb.f */
verilog/tpu_pkg.sv
verilog/wb_cmd_port.sv
verilog/tile_sequencer.sv
verilog/operand_banks.sv
verilog/systolic_array.sv
verilog/tpu_top.sv
tests/tpu_assertions.sv
tests/tb_tpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the systolic array testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tpu -f tb.f -o tb_tpu_sim

# an aborted simulation, for example a failed assertion, is a failure too
./obj_dir/tb_tpu_sim > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
